// File: source/monitor_pkg.sv
/*
 * Types and widths seen on the observed CPU bus,
 * the bus cycle struct and the watched RAM addresses
 */

`default_nettype none

package monitor_pkg;

	////////////////////
	// Bus widths

	typedef logic [15:0] addr_t;
	typedef logic [7:0]  data_t;
	typedef logic [15:0] pc_t;

	// Player score, most significant byte in bits 31:24
	typedef logic [31:0] score_t;

	// Three initials, first letter in bits 23:16
	typedef logic [23:0] initials_t;

	// One observed bus cycle
	typedef struct packed {
		pc_t   pc;
		logic  new_opcode;
		addr_t addr;
		data_t data;
		logic  write;
		// Last clock of the bus cycle
		logic  cycle_end;
	} cpu_bus_t;

	////////////////////
	// Watched RAM locations

	// Player one score bytes
	localparam addr_t SCORE_ADDR_0 = 16'hBDE4;
	localparam addr_t SCORE_ADDR_1 = 16'hBDE5;
	localparam addr_t SCORE_ADDR_2 = 16'hBDE6;
	localparam addr_t SCORE_ADDR_3 = 16'hBDE7;

	localparam addr_t WAVE_ADDR = 16'hBDED;

	// High score entry, one byte per letter
	localparam addr_t INITIALS_ADDR_0 = 16'hB3EA;
	localparam addr_t INITIALS_ADDR_1 = 16'hB3EB;
	localparam addr_t INITIALS_ADDR_2 = 16'hB3EC;

endpackage

`default_nettype wire

// File: source/event_pkg.sv
/*
 * Game event kinds, the one-hot event vector,
 * the event record and the game routine addresses
 */

`default_nettype none

package event_pkg;

	////////////////////
	// Event kinds

	// Values double as bit positions in event_vec_t
	typedef enum logic [3:0] {
		EV_BOOT            = 4'd0,
		EV_GAME_START      = 4'd1,
		EV_PLAYER_DEATH    = 4'd2,
		EV_STILL_TRYING    = 4'd3,
		EV_HUMAN_SAVED     = 4'd4,
		EV_HUMAN_KILLED    = 4'd5,
		EV_GRUNT_ELECTRODE = 4'd6,
		EV_GAME_OVER       = 4'd7,
		EV_ENFORCER_SPARK  = 4'd8,
		EV_SCORE_CHANGE    = 4'd9,
		EV_NVRAM_DUMP      = 4'd10,
		EV_WAVE_CHANGE     = 4'd11
	} event_kind_e;

	localparam int NUM_EVENTS = 12;

	// One pulse per event, never more than one bit high
	typedef logic [NUM_EVENTS-1:0] event_vec_t;

	// Payload is the new wave number for a wave change, else zero
	typedef struct packed {
		event_kind_e        kind;
		monitor_pkg::data_t payload;
	} event_rec_t;

	////////////////////
	// Routine entry points in the game program

	localparam monitor_pkg::pc_t PC_BOOT            = 16'hF000;
	localparam monitor_pkg::pc_t PC_GAME_START      = 16'h276C;
	localparam monitor_pkg::pc_t PC_PLAYER_DEATH    = 16'h30FE;
	localparam monitor_pkg::pc_t PC_STILL_TRYING    = 16'h3130;
	localparam monitor_pkg::pc_t PC_HUMAN_SAVED     = 16'h036A;
	localparam monitor_pkg::pc_t PC_HUMAN_KILLED    = 16'h03A2;
	localparam monitor_pkg::pc_t PC_GRUNT_ELECTRODE = 16'h3AA9;
	localparam monitor_pkg::pc_t PC_GAME_OVER       = 16'h3112;
	localparam monitor_pkg::pc_t PC_ENFORCER_SPARK  = 16'h147E;
	// Score redraw about to happen
	localparam monitor_pkg::pc_t PC_SCORE_CHANGE    = 16'hDC11;
	localparam monitor_pkg::pc_t PC_NVRAM_DUMP      = 16'hE727;

endpackage

`default_nettype wire

// File: source/pc_event_matcher.sv
/*
 * Routine event matcher: compares the program counter
 * against the routine table on each opcode fetch
 */

`default_nettype none

module pc_event_matcher (
	input  logic                  clk_12m,
	input  logic                  rst,
	input  monitor_pkg::cpu_bus_t bus_i,
	output event_pkg::event_vec_t pc_events_o
);

	event_pkg::event_vec_t pc_match;
	logic                  fetch_done;

	// Opcode fetch that completes on this clock
	assign fetch_done = bus_i.cycle_end && bus_i.new_opcode;

	////////////////////
	// Address compare

	always_comb begin
		pc_match = '0;
		pc_match[event_pkg::EV_BOOT]            = bus_i.pc == event_pkg::PC_BOOT;
		pc_match[event_pkg::EV_GAME_START]      = bus_i.pc == event_pkg::PC_GAME_START;
		pc_match[event_pkg::EV_PLAYER_DEATH]    = bus_i.pc == event_pkg::PC_PLAYER_DEATH;
		pc_match[event_pkg::EV_STILL_TRYING]    = bus_i.pc == event_pkg::PC_STILL_TRYING;
		pc_match[event_pkg::EV_HUMAN_SAVED]     = bus_i.pc == event_pkg::PC_HUMAN_SAVED;
		pc_match[event_pkg::EV_HUMAN_KILLED]    = bus_i.pc == event_pkg::PC_HUMAN_KILLED;
		pc_match[event_pkg::EV_GRUNT_ELECTRODE] = bus_i.pc == event_pkg::PC_GRUNT_ELECTRODE;
		pc_match[event_pkg::EV_GAME_OVER]       = bus_i.pc == event_pkg::PC_GAME_OVER;
		pc_match[event_pkg::EV_ENFORCER_SPARK]  = bus_i.pc == event_pkg::PC_ENFORCER_SPARK;
		pc_match[event_pkg::EV_SCORE_CHANGE]    = bus_i.pc == event_pkg::PC_SCORE_CHANGE;
		pc_match[event_pkg::EV_NVRAM_DUMP]      = bus_i.pc == event_pkg::PC_NVRAM_DUMP;
		// Wave changes come from RAM writes, not from the PC
	end

	// Single clock pulse after the fetch
	always_ff @(posedge clk_12m) begin
		if (rst) begin
			pc_events_o <= '0;
		end else if (fetch_done) begin
			pc_events_o <= pc_match;
		end else begin
			pc_events_o <= '0;
		end
	end

	////////////////////
	// Checks

	// Routine table entries must be distinct so a fetch hits at most one
	a_pc_events_onehot: assert property (
		@(posedge clk_12m) disable iff (rst)
		$onehot0(pc_events_o)
	) else $error("pc event vector has more than one bit set");

endmodule

`default_nettype wire

// File: source/write_snooper.sv
/*
 * Write snooper: captures score, wave and initials from
 * CPU writes and merges the wave event into the event vector
 */

`default_nettype none

module write_snooper (
	input  logic                   clk_12m,
	input  logic                   rst,
	input  monitor_pkg::cpu_bus_t  bus_i,
	input  event_pkg::event_vec_t  pc_events_i,
	output event_pkg::event_vec_t  events_o,
	output monitor_pkg::score_t    score_o,
	output monitor_pkg::data_t     wave_o,
	output monitor_pkg::initials_t initials_o
);

	logic write_done;
	logic wave_pulse;

	// Completed CPU write
	assign write_done = bus_i.cycle_end && bus_i.write;

	////////////////////
	// Score capture

	always_ff @(posedge clk_12m) begin
		if (rst) begin
			score_o <= '0;
		end else if (write_done) begin
			case (bus_i.addr)
				monitor_pkg::SCORE_ADDR_0: score_o[31:24] <= bus_i.data;
				monitor_pkg::SCORE_ADDR_1: score_o[23:16] <= bus_i.data;
				monitor_pkg::SCORE_ADDR_2: score_o[15:8]  <= bus_i.data;
				monitor_pkg::SCORE_ADDR_3: score_o[7:0]   <= bus_i.data;
				default: ;
			endcase
		end
	end

	////////////////////
	// Wave number

	always_ff @(posedge clk_12m) begin
		if (rst) begin
			wave_o     <= '0;
			wave_pulse <= 1'b0;
		end else begin
			wave_pulse <= write_done && (bus_i.addr == monitor_pkg::WAVE_ADDR);
			if (write_done && (bus_i.addr == monitor_pkg::WAVE_ADDR)) begin
				wave_o <= bus_i.data;
			end
		end
	end

	////////////////////
	// High score initials

	// Cleared at game start so an empty entry reads as zero
	always_ff @(posedge clk_12m) begin
		if (rst) begin
			initials_o <= '0;
		end else if (pc_events_i[event_pkg::EV_GAME_START]) begin
			initials_o <= '0;
		end else if (write_done) begin
			case (bus_i.addr)
				monitor_pkg::INITIALS_ADDR_0: initials_o[23:16] <= bus_i.data;
				monitor_pkg::INITIALS_ADDR_1: initials_o[15:8]  <= bus_i.data;
				monitor_pkg::INITIALS_ADDR_2: initials_o[7:0]   <= bus_i.data;
				default: ;
			endcase
		end
	end

	// Wave pulse lines up with the PC events, both one clock after cycle_end
	always_comb begin
		events_o = pc_events_i;
		events_o[event_pkg::EV_WAVE_CHANGE] = pc_events_i[event_pkg::EV_WAVE_CHANGE] | wave_pulse;
	end

	// A fetch is a read, so the two event sources never collide
	a_no_write_fetch: assert property (
		@(posedge clk_12m) disable iff (rst)
		bus_i.cycle_end |-> !(bus_i.write && bus_i.new_opcode)
	) else $error("bus cycle marked as both write and opcode fetch");

endmodule

`default_nettype wire

// File: source/event_queue.sv
/*
 * Event record queue: encodes event pulses into records,
 * buffers them and hands them to the host over req/ack
 */

`default_nettype none

module event_queue #(
	parameter int QUEUE_DEPTH = 8
) (
	input  logic                  clk_12m,
	input  logic                  rst,
	input  event_pkg::event_vec_t events_i,
	input  monitor_pkg::data_t    wave_i,
	output event_pkg::event_rec_t rec_o,
	output logic                  req_o,
	input  logic                  ack_i,
	output logic                  overflow_o
);

	localparam int PTR_W = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1;
	localparam int CNT_W = $clog2(QUEUE_DEPTH + 1);

	typedef enum logic [1:0] {
		DS_IDLE,
		DS_REQ,
		DS_RELEASE
	} deliver_state_e;

	event_pkg::event_rec_t mem [QUEUE_DEPTH];
	event_pkg::event_rec_t new_rec;
	logic [PTR_W-1:0]      wr_ptr;
	logic [PTR_W-1:0]      rd_ptr;
	logic [CNT_W-1:0]      count;
	logic                  push;
	logic                  full;
	logic                  pop;
	deliver_state_e        state;

	////////////////////
	// Record encode

	always_comb begin
		new_rec.kind = event_pkg::EV_BOOT;
		for (int i = 0; i < event_pkg::NUM_EVENTS; i++) begin
			if (events_i[i]) begin
				new_rec.kind = event_pkg::event_kind_e'(4'(i));
			end
		end
		new_rec.payload = events_i[event_pkg::EV_WAVE_CHANGE] ? wave_i : '0;
	end

	assign push = |events_i;
	assign full = count == CNT_W'(QUEUE_DEPTH);
	// Head entry is freed only once the host has dropped ack
	assign pop = (state == DS_RELEASE) && !ack_i;

	////////////////////
	// Circular buffer

	always_ff @(posedge clk_12m) begin
		if (push && !full) begin
			mem[wr_ptr] <= new_rec;
		end
	end

	always_ff @(posedge clk_12m) begin
		if (rst) begin
			wr_ptr     <= '0;
			rd_ptr     <= '0;
			count      <= '0;
			overflow_o <= 1'b0;
		end else begin
			if (push && !full) begin
				wr_ptr <= (wr_ptr == PTR_W'(QUEUE_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			end
			if (pop) begin
				rd_ptr <= (rd_ptr == PTR_W'(QUEUE_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			end
			count <= count + CNT_W'(push && !full) - CNT_W'(pop);
			// Sticky until reset
			if (push && full) begin
				overflow_o <= 1'b1;
			end
		end
	end

	assign rec_o = mem[rd_ptr];

	////////////////////
	// Delivery FSM

	always_ff @(posedge clk_12m) begin
		if (rst) begin
			state <= DS_IDLE;
			req_o <= 1'b0;
		end else begin
			case (state)
				DS_IDLE: begin
					if ((count != '0) && !ack_i) begin
						req_o <= 1'b1;
						state <= DS_REQ;
					end
				end
				DS_REQ: begin
					if (ack_i) begin
						req_o <= 1'b0;
						state <= DS_RELEASE;
					end
				end
				DS_RELEASE: begin
					if (!ack_i) begin
						state <= DS_IDLE;
					end
				end
				default: begin
					req_o <= 1'b0;
					state <= DS_IDLE;
				end
			endcase
		end
	end

	////////////////////
	// Handshake checks

	a_rec_stable: assert property (
		@(posedge clk_12m) disable iff (rst)
		($past(req_o) && req_o) |-> $stable(rec_o)
	) else $error("record changed while req was high");

	a_req_after_ack_low: assert property (
		@(posedge clk_12m) disable iff (rst)
		$rose(req_o) |-> !$past(ack_i)
	) else $error("req raised while ack was still high");

endmodule

`default_nettype wire

// File: source/game_monitor.sv
/*
 * Game monitor top level: routine event matcher,
 * write snooper and the event record queue
 */

`default_nettype none

module game_monitor #(
	parameter int QUEUE_DEPTH = 8
) (
	input  logic                   clk_12m,
	input  logic                   rst,
	input  monitor_pkg::cpu_bus_t  bus_i,
	output event_pkg::event_vec_t  events_o,
	output monitor_pkg::score_t    score_o,
	output monitor_pkg::data_t     wave_o,
	output monitor_pkg::initials_t initials_o,
	output event_pkg::event_rec_t  rec_o,
	output logic                   req_o,
	input  logic                   ack_i,
	output logic                   overflow_o
);

	event_pkg::event_vec_t pc_events;

	////////////////////
	// Program counter watch

	pc_event_matcher u_pc_event_matcher (
		.clk_12m     (clk_12m),
		.rst         (rst),
		.bus_i       (bus_i),
		.pc_events_o (pc_events)
	);

	////////////////////
	// RAM write capture

	write_snooper u_write_snooper (
		.clk_12m     (clk_12m),
		.rst         (rst),
		.bus_i       (bus_i),
		.pc_events_i (pc_events),
		.events_o    (events_o),
		.score_o     (score_o),
		.wave_o      (wave_o),
		.initials_o  (initials_o)
	);

	////////////////////
	// Host event log

	event_queue #(
		.QUEUE_DEPTH (QUEUE_DEPTH)
	) u_event_queue (
		.clk_12m    (clk_12m),
		.rst        (rst),
		.events_i   (events_o),
		.wave_i     (wave_o),
		.rec_o      (rec_o),
		.req_o      (req_o),
		.ack_i      (ack_i),
		.overflow_o (overflow_o)
	);

endmodule

`default_nettype wire

// File: bench/game_monitor_tb.sv
/*
 * Testbench for the game monitor: clock and reset, bus cycle driver,
 * host req/ack model, reference model and record compare
 */

`default_nettype none

module game_monitor_tb;

	localparam int QUEUE_DEPTH = 4;
	localparam int DRIVE_DLY   = 1;
	localparam int WAIT_LIMIT  = 400;

	// Expected visible state of the monitor
	typedef struct packed {
		monitor_pkg::score_t    score;
		monitor_pkg::data_t     wave;
		monitor_pkg::initials_t initials;
	} model_t;

	logic                   clk_12m;
	logic                   rst;
	monitor_pkg::cpu_bus_t  bus;
	event_pkg::event_vec_t  events;
	monitor_pkg::score_t    score;
	monitor_pkg::data_t     wave;
	monitor_pkg::initials_t initials;
	event_pkg::event_rec_t  rec;
	logic                   req;
	logic                   ack;
	logic                   overflow;

	model_t                model;
	event_pkg::event_rec_t exp_q[$];
	event_pkg::event_rec_t rx_q[$];
	logic                  host_en;
	logic                  exp_overflow;
	int                    error_count;
	int                    timeout_count;
	int                    seed;

	// Index equals the event kind
	monitor_pkg::pc_t routine_pc [11] = '{
		event_pkg::PC_BOOT,            event_pkg::PC_GAME_START,
		event_pkg::PC_PLAYER_DEATH,    event_pkg::PC_STILL_TRYING,
		event_pkg::PC_HUMAN_SAVED,     event_pkg::PC_HUMAN_KILLED,
		event_pkg::PC_GRUNT_ELECTRODE, event_pkg::PC_GAME_OVER,
		event_pkg::PC_ENFORCER_SPARK,  event_pkg::PC_SCORE_CHANGE,
		event_pkg::PC_NVRAM_DUMP
	};

	game_monitor #(
		.QUEUE_DEPTH (QUEUE_DEPTH)
	) uut (
		.clk_12m    (clk_12m),
		.rst        (rst),
		.bus_i      (bus),
		.events_o   (events),
		.score_o    (score),
		.wave_o     (wave),
		.initials_o (initials),
		.rec_o      (rec),
		.req_o      (req),
		.ack_i      (ack),
		.overflow_o (overflow)
	);

	initial begin
		clk_12m = 1'b0;
		forever #4 clk_12m = ~clk_12m;
	end

	////////////////////
	// Helpers

	task automatic check_value(input logic [31:0] got, input logic [31:0] want,
			input string what);
		if (got !== want) begin
			error_count++;
			$display("[ERROR] %0t: %s is %h, expected %h", $time, what, got, want);
		end
	endtask

	function automatic monitor_pkg::cpu_bus_t fetch_at(input monitor_pkg::pc_t pc,
			input logic opcode);
		monitor_pkg::cpu_bus_t b;
		b = '0;
		b.pc = pc;
		b.addr = pc;
		b.new_opcode = opcode;
		return b;
	endfunction

	function automatic monitor_pkg::cpu_bus_t access_at(input monitor_pkg::addr_t addr,
			input monitor_pkg::data_t data, input logic write);
		monitor_pkg::cpu_bus_t b;
		b = '0;
		b.pc = 16'hD000;
		b.addr = addr;
		b.data = data;
		b.write = write;
		return b;
	endfunction

	// Reference model returning 1 when the cycle raises an event
	function automatic logic predict_cycle(input monitor_pkg::cpu_bus_t b, input model_t cur,
			output model_t nxt, output event_pkg::event_kind_e kind);
		logic hit;
		nxt = cur;
		kind = event_pkg::EV_BOOT;
		hit = 1'b0;
		if (b.new_opcode && !b.write) begin
			for (int i = 0; i < 11; i++) begin
				if (b.pc == routine_pc[i]) begin
					hit = 1'b1;
					kind = event_pkg::event_kind_e'(4'(i));
				end
			end
			if (hit && kind == event_pkg::EV_GAME_START) begin
				nxt.initials = '0;
			end
		end else if (b.write) begin
			case (b.addr)
				monitor_pkg::SCORE_ADDR_0: nxt.score[31:24] = b.data;
				monitor_pkg::SCORE_ADDR_1: nxt.score[23:16] = b.data;
				monitor_pkg::SCORE_ADDR_2: nxt.score[15:8] = b.data;
				monitor_pkg::SCORE_ADDR_3: nxt.score[7:0] = b.data;
				monitor_pkg::WAVE_ADDR: begin
					nxt.wave = b.data;
					kind = event_pkg::EV_WAVE_CHANGE;
					hit = 1'b1;
				end
				monitor_pkg::INITIALS_ADDR_0: nxt.initials[23:16] = b.data;
				monitor_pkg::INITIALS_ADDR_1: nxt.initials[15:8] = b.data;
				monitor_pkg::INITIALS_ADDR_2: nxt.initials[7:0] = b.data;
				default: ;
			endcase
		end
		return hit;
	endfunction

	// Three clocks per bus cycle, then one clock to see the pulse
	task automatic bus_cycle(input monitor_pkg::cpu_bus_t b);
		model_t                 nxt;
		event_pkg::event_kind_e kind;
		event_pkg::event_vec_t  exp_vec;
		event_pkg::event_rec_t  exp_rec;
		logic                   hit;
		hit = predict_cycle(b, model, nxt, kind);
		exp_vec = '0;
		if (hit) begin
			exp_vec[kind] = 1'b1;
		end
		for (int i = 0; i < 3; i++) begin
			bus = b;
			bus.cycle_end = (i == 2);
			@(negedge clk_12m);
			check_value(events, '0, "events_o outside pulse");
			check_value(initials, model.initials, "initials_o");
			@(posedge clk_12m);
			#DRIVE_DLY;
		end
		bus.cycle_end = 1'b0;
		@(negedge clk_12m);
		check_value(events, exp_vec, "events_o");
		check_value(score, nxt.score, "score_o");
		check_value(wave, nxt.wave, "wave_o");
		model = nxt;
		if (hit) begin
			exp_rec.kind = kind;
			exp_rec.payload = (kind == event_pkg::EV_WAVE_CHANGE) ? nxt.wave : '0;
			// A full queue drops the record
			if (exp_q.size() < QUEUE_DEPTH) begin
				exp_q.push_back(exp_rec);
			end else begin
				exp_overflow = 1'b1;
			end
		end
		@(posedge clk_12m);
		#DRIVE_DLY;
	endtask

	task automatic wait_drain();
		int waited;
		waited = 0;
		while ((exp_q.size() != 0 || rx_q.size() != 0 || req || ack) && waited < WAIT_LIMIT) begin
			@(negedge clk_12m);
			waited++;
		end
		if (exp_q.size() != 0 || rx_q.size() != 0 || req || ack) begin
			timeout_count++;
			$display("Timed out at %0t waiting for the host to collect all records", $time);
		end
		@(posedge clk_12m);
		#DRIVE_DLY;
	endtask

	////////////////////
	// Host and compare

	initial begin : host
		event_pkg::event_rec_t got;
		int                    delay;
		int                    waited;
		forever begin
			@(negedge clk_12m);
			if (host_en && req) begin
				got = rec;
				delay = $unsigned($random(seed)) % 4;
				repeat (delay) @(posedge clk_12m);
				@(posedge clk_12m);
				#DRIVE_DLY;
				ack = 1'b1;
				waited = 0;
				do begin
					@(negedge clk_12m);
					waited++;
				end while (req && waited < WAIT_LIMIT);
				if (req) begin
					timeout_count++;
					$display("Timed out at %0t waiting for req_o to drop after ack", $time);
				end
				delay = $unsigned($random(seed)) % 4;
				repeat (delay) @(posedge clk_12m);
				@(posedge clk_12m);
				#DRIVE_DLY;
				ack = 1'b0;
				rx_q.push_back(got);
			end
		end
	end

	initial begin : compare
		event_pkg::event_rec_t got;
		event_pkg::event_rec_t want;
		forever begin
			@(negedge clk_12m);
			if (rx_q.size() > 0) begin
				got = rx_q.pop_front();
				if (exp_q.size() == 0) begin
					error_count++;
					$display("Record %h was delivered at %0t with no event pending", got, $time);
				end else begin
					want = exp_q.pop_front();
					check_value(got.kind, want.kind, "record kind");
					check_value(got.payload, want.payload, "record payload");
				end
			end
		end
	end

	initial begin : watchdog
		#200000;
		$display("Simulation did not finish within its time limit");
		$display("test failed");
		$finish;
	end

	////////////////////
	// Stimulus

	initial begin : stimulus
		monitor_pkg::cpu_bus_t b;
		monitor_pkg::addr_t    score_addr [4];
		int                    pick;
		seed = 32'h153b1a64;
		rst = 1'b1;
		bus = '0;
		ack = 1'b0;
		host_en = 1'b1;
		exp_overflow = 1'b0;
		error_count = 0;
		timeout_count = 0;
		model = '0;
		score_addr[0] = monitor_pkg::SCORE_ADDR_0;
		score_addr[1] = monitor_pkg::SCORE_ADDR_1;
		score_addr[2] = monitor_pkg::SCORE_ADDR_2;
		score_addr[3] = monitor_pkg::SCORE_ADDR_3;
		repeat (16) @(posedge clk_12m);
		#DRIVE_DLY;
		rst = 1'b0;
		@(negedge clk_12m);
		check_value({events, req, overflow}, '0, "event and handshake outputs after reset");
		check_value({score, wave, initials}, '0, "captured values after reset");
		@(posedge clk_12m);
		#DRIVE_DLY;

		// Routine fetches, then the same PCs without an opcode fetch
		for (int i = 0; i < 11; i++) begin
			bus_cycle(fetch_at(routine_pc[i], 1'b1));
			wait_drain();
			bus_cycle(fetch_at(routine_pc[i], 1'b0));
		end
		bus_cycle(fetch_at(16'h1234, 1'b1));

		// Score bytes most significant first, then reads
		for (int i = 0; i < 4; i++) begin
			bus_cycle(access_at(score_addr[i], 8'(8'h12 * i + 8'h01), 1'b1));
		end
		check_value(score, 32'h01132537, "score_o after four writes");
		for (int i = 0; i < 4; i++) begin
			bus_cycle(access_at(score_addr[i], 8'hEE, 1'b0));
		end
		check_value(score, 32'h01132537, "score_o after reads");

		// Wave number and its record payload
		bus_cycle(access_at(monitor_pkg::WAVE_ADDR, 8'h07, 1'b1));
		bus_cycle(access_at(monitor_pkg::WAVE_ADDR, 8'h08, 1'b1));
		wait_drain();
		check_value(wave, 8'h08, "wave_o");

		// Initials fill, then game start clears them
		bus_cycle(access_at(monitor_pkg::INITIALS_ADDR_0, 8'h41, 1'b1));
		bus_cycle(access_at(monitor_pkg::INITIALS_ADDR_1, 8'h42, 1'b1));
		bus_cycle(access_at(monitor_pkg::INITIALS_ADDR_2, 8'h43, 1'b1));
		check_value(initials, 24'h414243, "initials_o after writes");
		bus_cycle(fetch_at(event_pkg::PC_GAME_START, 1'b1));
		wait_drain();
		check_value(initials, '0, "initials_o after game start");

		// Random traffic with at most three events outstanding
		for (int r = 0; r < 12; r++) begin
			for (int k = 0; k < 3; k++) begin
				pick = $unsigned($random(seed)) % 4;
				case (pick)
					0: b = fetch_at(routine_pc[$unsigned($random(seed)) % 11], 1'b1);
					1: b = access_at(monitor_pkg::WAVE_ADDR, 8'($random(seed)), 1'b1);
					2: b = access_at(monitor_pkg::SCORE_ADDR_3, 8'($random(seed)), 1'b1);
					default: b = fetch_at(16'($random(seed)), 1'b1);
				endcase
				bus_cycle(b);
			end
			wait_drain();
		end
		check_value(overflow, 1'b0, "overflow_o after random traffic");

		// Six events into a stalled queue of four
		host_en = 1'b0;
		for (int i = 0; i < 6; i++) begin
			bus_cycle(fetch_at(routine_pc[i + 2], 1'b1));
		end
		check_value(overflow, exp_overflow, "overflow_o with host stalled");
		host_en = 1'b1;
		wait_drain();
		repeat (20) @(negedge clk_12m);
		check_value(req, 1'b0, "req_o after the kept records");

		$display("Checks done: %0d mismatches, %0d timeouts", error_count, timeout_count);
		if (error_count == 0 && timeout_count == 0) begin
			$display("test passed");
		end else begin
			$display("test failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: game_monitor.f
source/monitor_pkg.sv
source/event_pkg.sv
source/pc_event_matcher.sv
source/write_snooper.sv
source/event_queue.sv
source/game_monitor.sv
bench/game_monitor_tb.sv

// File: Bender.yml
package:
  name: game_monitor

sources:
  - files:
      - source/monitor_pkg.sv
      - source/event_pkg.sv
      - source/pc_event_matcher.sv
      - source/write_snooper.sv
      - source/event_queue.sv
      - source/game_monitor.sv
  - target: test
    files:
      - bench/game_monitor_tb.sv
